// File: bench/frame_checker.sv
`default_nettype none
`timescale 1ns/100ps

`include "frame_settings.svh"

module frame_checker (
  input  logic                    RD_CLK,
  input  logic                    WR_RESET,
  input  logic                    cfg_we,
  input  logic                    cfg_addr,
  input  logic [7:0]              cfg_wdata,
  input  logic                    in_valid,
  input  frame_pkg::sample_t      sample,
  input  logic [`TS_WIDTH-1:0]    time_stamp,
  input  logic [`ADC_WIDTH-1:0]   baseline,
  input  logic [`ADC_WIDTH:0]     threshold,
  input  logic                    in_ready,
  input  logic                    out_valid,
  input  frame_pkg::out_word_t    dout,
  output int                      errors,
  output int                      frames,
  output int                      pending,
  output logic                    idle
);

  import frame_pkg::*;

  logic [`PRE_LEN_WIDTH-1:0] pre_len_m;
  logic [`CH_ID_WIDTH-1:0]   channel_m;
  logic [`PRE_LEN_WIDTH-1:0] hold_m;
  sample_t                   words [$];
  int                        n_words = 0;
  logic [`TS_WIDTH-1:0]      first_ts;
  logic [`ADC_WIDTH-1:0]     first_bl;
  logic [`ADC_WIDTH:0]       first_th;
  logic [`CH_ID_WIDTH-1:0]   first_ch;
  out_word_t                 expected [$];
  int                        pushed = 0;
  int                        popped = 0;
  int                        err_count = 0;
  int                        frame_count = 0;
  logic                      rst_q = 1'b0;

  assign errors = err_count;
  assign frames = frame_count;
  assign pending = pushed - popped;
  assign idle = (pending == 0) && (n_words == 0) && (hold_m == '0);

  // header, low then high half of each word, footer
  function automatic void build_frame(input int n);
    out_word_t   hdr;
    out_word_t   ftr;
    logic [15:0] bl_ext;
    logic [15:0] th_ext;
    int          i;
    bl_ext = 16'($signed(first_bl));
    th_ext = 16'($signed(first_th));
    hdr = {`HEADER_ID, first_ch, first_ts[31:0], `FRAME_LEN_WIDTH'(2 * n)};
    ftr = {bl_ext, th_ext, first_ts[`TS_WIDTH-1:32], `FOOTER_ID};
    expected.push_back(hdr);
    for (i = 0; i < n; i++) begin
      expected.push_back(words[i][`OUT_WIDTH-1:0]);
      expected.push_back(words[i][`SAMPLE_WIDTH-1:`OUT_WIDTH]);
    end
    expected.push_back(ftr);
    pushed += 2 * n + 2;
    frame_count++;
  endfunction

  // gate, hold counter and frame cuts seen from the input ports
  always @(posedge RD_CLK) begin : model
    logic [`PRE_LEN_WIDTH-1:0] pre_old;
    logic                      take;
    if (WR_RESET) begin
      pre_len_m = '0;
      channel_m = '0;
      hold_m = '0;
      words.delete();
      n_words = 0;
    end else begin
      pre_old = pre_len_m;
      if (cfg_we && !cfg_addr) begin
        pre_len_m = cfg_wdata[`PRE_LEN_WIDTH-1:0];
      end
      if (cfg_we && cfg_addr) begin
        channel_m = cfg_wdata[`CH_ID_WIDTH-1:0];
      end
      take = in_valid || hold_m != '0;
      // bursts never fill a FIFO, so every gated sample must be accepted
      if (take && in_ready !== 1'b1) begin
        $display("error at %0t: in_ready is %b while the gate is open, expected 1",
          $time, in_ready);
        err_count++;
      end
      if (in_valid) begin
        hold_m = pre_old;
      end else if (hold_m != '0) begin
        hold_m = hold_m - 1'b1;
      end
      if (take) begin
        if (n_words == 0) begin
          first_ts = time_stamp;
          first_bl = baseline;
          first_th = threshold;
          first_ch = channel_m;
        end
        words.push_back(sample);
        n_words = words.size();
        if (n_words == `FRAME_MAX_WORDS) begin
          build_frame(n_words);
          words.delete();
          n_words = 0;
        end
      end else if (n_words != 0) begin
        // gate closed, frame ends with what it has
        build_frame(n_words);
        words.delete();
        n_words = 0;
      end
    end
  end

  always @(posedge RD_CLK) begin : compare
    out_word_t exp_word;
    if (rst_q && (out_valid !== 1'b0 || in_ready !== 1'b0)) begin
      $display("error at %0t: out_valid %b in_ready %b after a reset cycle, both should be low",
        $time, out_valid, in_ready);
      err_count++;
    end
    if (!WR_RESET && out_valid === 1'b1) begin
      if (expected.size() == 0) begin
        $display("output word %h at %0t came out while no frame was expected", dout, $time);
        err_count++;
      end else begin
        exp_word = expected.pop_front();
        if (dout !== exp_word) begin
          $display("error at %0t: output word %0d expected %h, got %h",
            $time, popped, exp_word, dout);
          err_count++;
        end
        popped++;
      end
    end
    rst_q = WR_RESET;
  end

endmodule

`default_nettype wire

// File: bench/frame_tb.sv
`default_nettype none
`timescale 1ns/100ps

`include "frame_settings.svh"

module frame_tb;

  import frame_pkg::*;

  // driven cycles over all tests, rounded up
  localparam int STIM_CYCLES = 80;
  localparam int CYCLE_LIMIT = 4 * STIM_CYCLES + 200;
  localparam int DRAIN_LIMIT = 100;

  logic                    RD_CLK = 1'b0;
  logic                    WR_RESET;
  logic                    cfg_we;
  logic                    cfg_addr;
  logic [7:0]              cfg_wdata;
  logic                    in_valid;
  sample_t                 sample;
  logic [`TS_WIDTH-1:0]    time_stamp;
  logic [`ADC_WIDTH-1:0]   baseline;
  logic [`ADC_WIDTH:0]     threshold;
  logic                    in_ready;
  logic                    out_valid;
  out_word_t               dout;

  int   chk_errors;
  int   chk_frames;
  int   chk_pending;
  logic chk_idle;

  int   tests_run = 0;
  int   tests_failed = 0;
  int   errors_at_start;
  int   frames_at_start;
  logic test_ok;

  always #2 RD_CLK = ~RD_CLK;

  frame_builder_top UUT (
    .RD_CLK     (RD_CLK),
    .WR_RESET   (WR_RESET),
    .cfg_we     (cfg_we),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .in_valid   (in_valid),
    .sample     (sample),
    .time_stamp (time_stamp),
    .baseline   (baseline),
    .threshold  (threshold),
    .in_ready   (in_ready),
    .out_valid  (out_valid),
    .dout       (dout)
  );

  frame_checker u_checker (
    .RD_CLK     (RD_CLK),
    .WR_RESET   (WR_RESET),
    .cfg_we     (cfg_we),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .in_valid   (in_valid),
    .sample     (sample),
    .time_stamp (time_stamp),
    .baseline   (baseline),
    .threshold  (threshold),
    .in_ready   (in_ready),
    .out_valid  (out_valid),
    .dout       (dout),
    .errors     (chk_errors),
    .frames     (chk_frames),
    .pending    (chk_pending),
    .idle       (chk_idle)
  );

  // new random sample fields every cycle, trigger level as given
  task automatic drive_cycle(input logic valid, input logic neg_adc);
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    logic [31:0] r4;
    logic [31:0] r5;
    logic [31:0] r6;
    r0 = $urandom();
    r1 = $urandom();
    r2 = $urandom();
    r3 = $urandom();
    r4 = $urandom();
    r5 = $urandom();
    r6 = $urandom();
    @(posedge RD_CLK);
    in_valid <= valid;
    sample <= {r3, r2, r1, r0};
    time_stamp <= {r4[15:0], r5};
    baseline <= neg_adc ? {1'b1, r4[26:16]} : r4[27:16];
    threshold <= neg_adc ? {1'b1, r6[11:0]} : r6[12:0];
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) drive_cycle(1'b0, 1'b0);
  endtask

  task automatic trigger_burst(input int n, input logic neg_adc);
    repeat (n) drive_cycle(1'b1, neg_adc);
  endtask

  task automatic write_cfg(input logic addr, input logic [7:0] data);
    @(posedge RD_CLK);
    cfg_we <= 1'b1;
    cfg_addr <= addr;
    cfg_wdata <= data;
    in_valid <= 1'b0;
    @(posedge RD_CLK);
    cfg_we <= 1'b0;
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (in_ready !== 1'b1 && n < 10) begin
      @(negedge RD_CLK);
      n++;
    end
    if (in_ready !== 1'b1) begin
      $display("in_ready did not go high within 10 cycles after reset");
      test_ok = 1'b0;
    end
  endtask

  task automatic start_test();
    errors_at_start = chk_errors;
    frames_at_start = chk_frames;
    test_ok = 1'b1;
  endtask

  // let the last frame drain, then report the test
  task automatic finish_test(input int num, input string name, input int exp_frames);
    int waited;
    int built;
    idle_cycles(2);
    waited = 0;
    @(negedge RD_CLK);
    while (!chk_idle && waited < DRAIN_LIMIT) begin
      @(negedge RD_CLK);
      waited++;
    end
    if (!chk_idle) begin
      $display("test %0d: output did not drain, %0d expected words never came out",
        num, chk_pending);
      test_ok = 1'b0;
    end
    built = chk_frames - frames_at_start;
    if (built != exp_frames) begin
      $display("test %0d: %0d frames were cut where %0d were expected", num, built, exp_frames);
      test_ok = 1'b0;
    end
    if (chk_errors != errors_at_start) begin
      test_ok = 1'b0;
    end
    tests_run++;
    if (test_ok) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed", num, name);
    end
  endtask

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge RD_CLK);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'hb03ae2ea));
    WR_RESET <= 1'b1;
    cfg_we <= 1'b0;
    cfg_addr <= 1'b0;
    cfg_wdata <= 8'd0;
    in_valid <= 1'b0;
    sample <= '0;
    time_stamp <= '0;
    baseline <= '0;
    threshold <= '0;

    start_test();
    repeat (3) @(posedge RD_CLK);
    WR_RESET <= 1'b0;
    wait_ready();
    finish_test(1, "reset and ready", 0);

    start_test();
    write_cfg(1'b0, 8'd0);
    trigger_burst(3, 1'b0);
    finish_test(2, "short trigger, no hold", 1);

    // tail words carry whatever sample is on the bus
    start_test();
    write_cfg(1'b0, 8'd4);
    trigger_burst(3, 1'b0);
    finish_test(3, "short trigger, hold of 4", 1);

    start_test();
    write_cfg(1'b0, 8'd0);
    trigger_burst(20, 1'b0);
    finish_test(4, "long trigger split 8/8/4", 3);

    start_test();
    write_cfg(1'b1, 8'd9);
    trigger_burst(3, 1'b1);
    finish_test(5, "channel 9, negative adc fields", 1);

    // 2 + gap 2 + 1 + hold 3 fills exactly one frame
    start_test();
    write_cfg(1'b0, 8'd3);
    trigger_burst(2, 1'b0);
    idle_cycles(2);
    trigger_burst(1, 1'b0);
    finish_test(6, "gap shorter than hold", 1);

    start_test();
    trigger_burst(2, 1'b0);
    idle_cycles(5);
    trigger_burst(2, 1'b0);
    finish_test(7, "gap longer than hold", 2);

    $display("%0d tests, %0d passed, %0d failed, %0d word errors",
      tests_run, tests_run - tests_failed, tests_failed, chk_errors);
    if (tests_failed == 0 && chk_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module frame_tb -Mdir obj_dir -o frame_sim

status=0
out=$(./obj_dir/frame_sim) || status=$?
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "ALL TESTS PASSED"; then
  exit 0
fi
echo "simulation failed (exit status $status)"
exit 1

// File: sources.f
+incdir+src
src/frame_pkg.sv
src/fifo_if.sv
src/sync_fifo.sv
src/frame_config.sv
src/trigger_stretcher.sv
src/frame_writer.sv
src/frame_reader.sv
src/frame_builder_top.sv
bench/frame_checker.sv
bench/frame_tb.sv

// File: src/fifo_if.sv
`default_nettype none
`timescale 1ns/100ps

interface fifo_if #(
  parameter type payload_t = logic
) ();

  logic     push;
  payload_t wdata;
  logic     pop;
  payload_t rdata;
  logic     empty;
  logic     full;

  modport producer (
    output push,
    output wdata,
    input  full
  );

  modport store (
    input  push,
    input  wdata,
    input  pop,
    output rdata,
    output empty,
    output full
  );

  modport consumer (
    output pop,
    input  rdata,
    input  empty
  );

endinterface

`default_nettype wire

// File: src/frame_builder_top.sv
`default_nettype none
`timescale 1ns/100ps

`include "frame_settings.svh"

module frame_builder_top (
  input  logic                   RD_CLK,
  input  logic                   WR_RESET,
  input  logic                   cfg_we,
  input  logic                   cfg_addr,
  input  logic [7:0]             cfg_wdata,
  input  logic                   in_valid,
  input  frame_pkg::sample_t     sample,
  input  logic [`TS_WIDTH-1:0]   time_stamp,
  input  logic [`ADC_WIDTH-1:0]  baseline,
  input  logic [`ADC_WIDTH:0]    threshold,
  output logic                   in_ready,
  output logic                   out_valid,
  output frame_pkg::out_word_t   dout
);

  import frame_pkg::*;

  logic [`PRE_LEN_WIDTH-1:0] pre_len;
  logic [`CH_ID_WIDTH-1:0]   channel_id;
  logic                      gate;

  fifo_if #(.payload_t(sample_t))     data_bus ();
  fifo_if #(.payload_t(frame_info_t)) info_bus ();

  frame_config u_config (
    .RD_CLK     (RD_CLK),
    .WR_RESET   (WR_RESET),
    .cfg_we     (cfg_we),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .pre_len    (pre_len),
    .channel_id (channel_id)
  );

  trigger_stretcher u_stretcher (
    .RD_CLK   (RD_CLK),
    .WR_RESET (WR_RESET),
    .in_valid (in_valid),
    .pre_len  (pre_len),
    .gate     (gate)
  );

  frame_writer u_writer (
    .RD_CLK     (RD_CLK),
    .WR_RESET   (WR_RESET),
    .gate       (gate),
    .sample     (sample),
    .time_stamp (time_stamp),
    .baseline   (baseline),
    .threshold  (threshold),
    .channel_id (channel_id),
    .in_ready   (in_ready),
    .data_bus   (data_bus.producer),
    .info_bus   (info_bus.producer)
  );

  sync_fifo #(
    .payload_t (sample_t),
    .DEPTH     (`DATA_FIFO_DEPTH)
  ) u_data_fifo (
    .RD_CLK   (RD_CLK),
    .WR_RESET (WR_RESET),
    .bus      (data_bus.store)
  );

  sync_fifo #(
    .payload_t (frame_info_t),
    .DEPTH     (`INFO_FIFO_DEPTH)
  ) u_info_fifo (
    .RD_CLK   (RD_CLK),
    .WR_RESET (WR_RESET),
    .bus      (info_bus.store)
  );

  frame_reader u_reader (
    .RD_CLK    (RD_CLK),
    .WR_RESET  (WR_RESET),
    .data_bus  (data_bus.consumer),
    .info_bus  (info_bus.consumer),
    .out_valid (out_valid),
    .dout      (dout)
  );

endmodule

`default_nettype wire

// File: src/frame_config.sv
`default_nettype none
`timescale 1ns/100ps

`include "frame_settings.svh"

module frame_config (
  input  logic                      RD_CLK,
  input  logic                      WR_RESET,
  input  logic                      cfg_we,
  input  logic                      cfg_addr,
  input  logic [7:0]                cfg_wdata,
  output logic [`PRE_LEN_WIDTH-1:0] pre_len,
  output logic [`CH_ID_WIDTH-1:0]   channel_id
);

  // addr 0 pre_len, addr 1 channel id
  always_ff @(posedge RD_CLK) begin
    if (WR_RESET) begin
      pre_len <= '0;
      channel_id <= '0;
    end else if (cfg_we) begin
      if (cfg_addr == 1'b0) begin
        pre_len <= cfg_wdata[`PRE_LEN_WIDTH-1:0];
      end else begin
        channel_id <= cfg_wdata[`CH_ID_WIDTH-1:0];
      end
    end
  end

endmodule

`default_nettype wire

// File: src/frame_pkg.sv
`default_nettype none

`include "frame_settings.svh"

package frame_pkg;

  typedef logic [`SAMPLE_WIDTH-1:0] sample_t;

  typedef logic [`OUT_WIDTH-1:0] out_word_t;

  // first word of every frame
  typedef struct packed {
    logic [15:0]                  id;
    logic [`CH_ID_WIDTH-1:0]      channel;
    logic [31:0]                  ts_low;
    logic [`FRAME_LEN_WIDTH-1:0]  length;
  } frame_header_t;

  // last word, baseline and threshold sign-extended
  typedef struct packed {
    logic [15:0] baseline;
    logic [15:0] threshold;
    logic [15:0] ts_high;
    logic [15:0] id;
  } frame_footer_t;

  typedef struct packed {
    frame_footer_t footer;
    frame_header_t header;
  } frame_info_t;

endpackage

`default_nettype wire

// File: src/frame_reader.sv
`default_nettype none
`timescale 1ns/100ps

`include "frame_settings.svh"

module frame_reader (
  input  logic                RD_CLK,
  input  logic                WR_RESET,
  fifo_if.consumer            data_bus,
  fifo_if.consumer            info_bus,
  output logic                out_valid,
  output frame_pkg::out_word_t dout
);

  import frame_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    HEADER,
    DATA_LOW,
    DATA_HIGH,
    FOOTER
  } state_t;

  state_t                       state;
  frame_info_t                  info_q;
  logic [`FRAME_LEN_WIDTH-2:0]  remain;
  sample_t                      word;

  assign info_bus.pop = (state == IDLE) & ~info_bus.empty;
  assign data_bus.pop = (state == DATA_HIGH);
  assign word = data_bus.rdata;

  always_ff @(posedge RD_CLK) begin
    if (WR_RESET) begin
      state <= IDLE;
      out_valid <= 1'b0;
      remain <= '0;
    end else begin
      out_valid <= (state != IDLE);
      case (state)
        IDLE: begin
          if (!info_bus.empty) begin
            state <= HEADER;
          end
        end
        HEADER: begin
          // length counts 64-bit halves
          remain <= info_q.header.length[`FRAME_LEN_WIDTH-1:1];
          state <= DATA_LOW;
        end
        DATA_LOW: begin
          state <= DATA_HIGH;
        end
        DATA_HIGH: begin
          remain <= remain - 1'b1;
          state <= (remain == 1) ? FOOTER : DATA_LOW;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge RD_CLK) begin
    if (info_bus.pop) begin
      info_q <= info_bus.rdata;
    end
    case (state)
      HEADER: dout <= info_q.header;
      DATA_LOW: dout <= word[`OUT_WIDTH-1:0];
      DATA_HIGH: dout <= word[`SAMPLE_WIDTH-1:`OUT_WIDTH];
      FOOTER: dout <= info_q.footer;
      default: dout <= dout;
    endcase
  end

  // frame data must already sit in the data FIFO once its info is read
  a_data_present: assert property (@(posedge RD_CLK) disable iff (WR_RESET)
    (state inside {DATA_LOW, DATA_HIGH}) |-> !data_bus.empty);

endmodule

`default_nettype wire

// File: src/frame_settings.svh
`ifndef FRAME_SETTINGS_SVH
`define FRAME_SETTINGS_SVH

// word widths
`define SAMPLE_WIDTH     128
`define OUT_WIDTH        64
`define TS_WIDTH         48
`define ADC_WIDTH        12

// configuration fields
`define PRE_LEN_WIDTH    5
`define CH_ID_WIDTH      4

// framing
`define FRAME_MAX_WORDS  8
`define FRAME_LEN_WIDTH  12
`define HEADER_ID        16'hAAAA
`define FOOTER_ID        16'h5555

// buffer depths
`define DATA_FIFO_DEPTH  64
`define INFO_FIFO_DEPTH  8

`endif

// File: src/frame_writer.sv
`default_nettype none
`timescale 1ns/100ps

`include "frame_settings.svh"

module frame_writer (
  input  logic                    RD_CLK,
  input  logic                    WR_RESET,
  input  logic                    gate,
  input  frame_pkg::sample_t      sample,
  input  logic [`TS_WIDTH-1:0]    time_stamp,
  input  logic [`ADC_WIDTH-1:0]   baseline,
  input  logic [`ADC_WIDTH:0]     threshold,
  input  logic [`CH_ID_WIDTH-1:0] channel_id,
  output logic                    in_ready,
  fifo_if.producer                data_bus,
  fifo_if.producer                info_bus
);

  import frame_pkg::*;

  localparam int CW = $clog2(`FRAME_MAX_WORDS + 1);

  logic                  gate_q;
  sample_t               sample_q;
  logic [`TS_WIDTH-1:0]  ts_q;
  logic [`ADC_WIDTH-1:0] bl_q;
  logic [`ADC_WIDTH:0]   th_q;
  logic [CW-1:0]         cnt;
  logic [CW-1:0]         words;
  logic                  cut;
  frame_header_t         hdr_new;
  frame_footer_t         ftr_new;
  frame_header_t         hdr_q;
  frame_footer_t         ftr_q;
  frame_info_t           info_next;
  frame_info_t           info_q;
  logic                  info_push;

  always_ff @(posedge RD_CLK) begin
    if (WR_RESET) begin
      gate_q <= 1'b0;
      in_ready <= 1'b0;
    end else begin
      // samples offered while not ready are dropped
      gate_q <= gate & in_ready;
      in_ready <= ~data_bus.full & ~info_bus.full;
    end
  end

  always_ff @(posedge RD_CLK) begin
    sample_q <= sample;
    ts_q <= time_stamp;
    bl_q <= baseline;
    th_q <= threshold;
  end

  assign words = cnt + 1'b1;

  // last word of the frame is being pushed now
  assign cut = gate_q & ((words == CW'(`FRAME_MAX_WORDS)) | ~(gate & in_ready));

  always_comb begin
    hdr_new.id = `HEADER_ID;
    hdr_new.channel = channel_id;
    hdr_new.ts_low = ts_q[31:0];
    hdr_new.length = '0;
    ftr_new.baseline = {{(16 - `ADC_WIDTH){bl_q[`ADC_WIDTH-1]}}, bl_q};
    ftr_new.threshold = {{(15 - `ADC_WIDTH){th_q[`ADC_WIDTH]}}, th_q};
    ftr_new.ts_high = ts_q[`TS_WIDTH-1:32];
    ftr_new.id = `FOOTER_ID;
  end

  // a one-word frame has not captured its fields yet
  always_comb begin
    info_next.header = (cnt == '0) ? hdr_new : hdr_q;
    info_next.footer = (cnt == '0) ? ftr_new : ftr_q;
    info_next.header.length = `FRAME_LEN_WIDTH'({words, 1'b0});
  end

  always_ff @(posedge RD_CLK) begin
    if (WR_RESET) begin
      cnt <= '0;
      info_push <= 1'b0;
    end else begin
      info_push <= cut;
      if (cut) begin
        cnt <= '0;
      end else if (gate_q) begin
        cnt <= words;
      end
    end
  end

  always_ff @(posedge RD_CLK) begin
    if (gate_q && cnt == '0) begin
      hdr_q <= hdr_new;
      ftr_q <= ftr_new;
    end
    if (cut) begin
      info_q <= info_next;
    end
  end

  assign data_bus.push = gate_q;
  assign data_bus.wdata = sample_q;
  assign info_bus.push = info_push;
  assign info_bus.wdata = info_q;

  a_frame_len: assert property (@(posedge RD_CLK) disable iff (WR_RESET)
    gate_q |-> (words <= CW'(`FRAME_MAX_WORDS)));

endmodule

`default_nettype wire

// File: src/sync_fifo.sv
`default_nettype none
`timescale 1ns/100ps

module sync_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 8
) (
  input logic   RD_CLK,
  input logic   WR_RESET,
  fifo_if.store bus
);

  localparam int AW = $clog2(DEPTH);

  payload_t      mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          do_push;
  logic          do_pop;

  assign do_push = bus.push & ~bus.full;
  assign do_pop = bus.pop & ~bus.empty;

  // head entry always visible
  assign bus.rdata = mem[rd_ptr];
  assign bus.empty = (count == '0);
  assign bus.full = (count == (AW+1)'(DEPTH));

  always_ff @(posedge RD_CLK) begin
    if (do_push) begin
      mem[wr_ptr] <= bus.wdata;
    end
  end

  always_ff @(posedge RD_CLK) begin
    if (WR_RESET) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_no_overflow: assert property (@(posedge RD_CLK) disable iff (WR_RESET)
    !(bus.push && bus.full));

  a_no_underflow: assert property (@(posedge RD_CLK) disable iff (WR_RESET)
    !(bus.pop && bus.empty));

endmodule

`default_nettype wire

// File: src/trigger_stretcher.sv
`default_nettype none
`timescale 1ns/100ps

`include "frame_settings.svh"

module trigger_stretcher (
  input  logic                      RD_CLK,
  input  logic                      WR_RESET,
  input  logic                      in_valid,
  input  logic [`PRE_LEN_WIDTH-1:0] pre_len,
  output logic                      gate
);

  logic [`PRE_LEN_WIDTH-1:0] hold;

  // reload while triggered, drain afterwards
  always_ff @(posedge RD_CLK) begin
    if (WR_RESET) begin
      hold <= '0;
    end else if (in_valid) begin
      hold <= pre_len;
    end else if (hold != '0) begin
      hold <= hold - 1'b1;
    end
  end

  assign gate = in_valid | (hold != '0);

endmodule

`default_nettype wire
